//--- common/io_pkg.sv
`default_nettype none

package io_pkg;

  // Requesters and their tags
  localparam int NUM_CORES = 4;
  localparam int CORE_ID_WIDTH = 2;
  localparam int THREAD_IDX_WIDTH = 2;

  // IO bus widths
  localparam int IO_ADDR_WIDTH = 16;
  localparam int IO_DATA_WIDTH = 32;

  // Scratch register bank, one word every 4 bytes
  localparam int REG_BANK_WORDS = 16;
  localparam int REG_IDX_WIDTH = 4;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_BANK_BASE = 16'h0000;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_BANK_BYTES = 16'h0040;

  // Accumulator ports
  localparam logic [IO_ADDR_WIDTH-1:0] ACCUM_ADD_ADDR = 16'h0040;
  localparam logic [IO_ADDR_WIDTH-1:0] ACCUM_LOAD_ADDR = 16'h0044;

  // Request opcode
  typedef enum logic
  {
    IO_READ = 1'b0,
    IO_WRITE = 1'b1
  } io_op_e;

endpackage

`default_nettype wire

//--- logic/rr_arbiter.sv
`default_nettype none

module rr_arbiter
  import io_pkg::*;
(
  input wire clk,
  input wire reset,
  input wire [NUM_CORES-1:0] request,
  input wire update_pointer,
  output logic [NUM_CORES-1:0] grant_oh,
  output logic [CORE_ID_WIDTH-1:0] grant_idx
);

  // Core with the highest priority in the current cycle
  logic [CORE_ID_WIDTH-1:0] pointer;
  logic [CORE_ID_WIDTH-1:0] candidate;
  logic found;

  // Walk the cores starting at the pointer, wrapping after the last one
  always_comb
  begin
    grant_oh = '0;
    found = 1'b0;
    candidate = '0;
    for (int i = 0; i < NUM_CORES; i++)
    begin
      candidate = CORE_ID_WIDTH'((int'(pointer) + i) % NUM_CORES);
      if (!found && request[candidate])
      begin
        grant_oh[candidate] = 1'b1;
        found = 1'b1;
      end
    end
  end

  // One-hot to index
  always_comb
  begin
    grant_idx = '0;
    for (int i = 0; i < NUM_CORES; i++)
    begin
      if (grant_oh[i])
        grant_idx = grant_idx | CORE_ID_WIDTH'(i);
    end
  end

  // Winner drops to lowest priority
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      pointer <= '0;
    else if (update_pointer && found)
    begin
      if (grant_idx == CORE_ID_WIDTH'(NUM_CORES - 1))
        pointer <= '0;
      else
        pointer <= grant_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/io_bus_decoder.sv
`default_nettype none

module io_bus_decoder
  import io_pkg::*;
(
  input wire clk,
  input wire reset,
  input wire bus_read_en,
  input wire bus_write_en,
  input wire [IO_ADDR_WIDTH-1:0] bus_addr,
  output logic reg_sel,
  output logic accum_sel,
  input wire [IO_DATA_WIDTH-1:0] reg_read_data,
  input wire [IO_DATA_WIDTH-1:0] accum_read_data,
  output logic [IO_DATA_WIDTH-1:0] bus_read_data
);

  logic reg_hit;
  logic accum_hit;
  logic bus_access;

  // Device that was read in the previous cycle
  logic read_reg_q;
  logic read_accum_q;

  assign reg_hit = (bus_addr & ~(REG_BANK_BYTES - 1'b1)) == REG_BANK_BASE;
  assign accum_hit = (bus_addr == ACCUM_ADD_ADDR) || (bus_addr == ACCUM_LOAD_ADDR);
  assign bus_access = bus_read_en || bus_write_en;

  assign reg_sel = reg_hit && bus_access;
  assign accum_sel = accum_hit && bus_access;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      read_reg_q <= 1'b0;
      read_accum_q <= 1'b0;
    end
    else
    begin
      read_reg_q <= bus_read_en && reg_hit;
      read_accum_q <= bus_read_en && accum_hit;
    end
  end

  // Unmapped reads and non-read cycles return zero
  always_comb
  begin
    if (read_reg_q)
      bus_read_data = reg_read_data;
    else if (read_accum_q)
      bus_read_data = accum_read_data;
    else
      bus_read_data = '0;
  end

endmodule

`default_nettype wire

//--- io_devices/io_register_bank.sv
`default_nettype none

module io_register_bank
  import io_pkg::*;
(
  input wire clk,
  input wire reset,
  input wire sel,
  input wire write_en,
  input wire read_en,
  input wire [IO_ADDR_WIDTH-1:0] addr,
  input wire [IO_DATA_WIDTH-1:0] write_data,
  output logic [IO_DATA_WIDTH-1:0] read_data
);

  logic [IO_DATA_WIDTH-1:0] regs [REG_BANK_WORDS];
  logic [REG_IDX_WIDTH-1:0] reg_idx;

  // Word index, byte offset bits dropped
  assign reg_idx = addr[REG_IDX_WIDTH+1:2];

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < REG_BANK_WORDS; i++)
        regs[i] <= '0;
    end
    else if (sel && write_en)
      regs[reg_idx] <= write_data;
  end

  // Read data is held until the next selected read
  always_ff @(posedge clk)
  begin
    if (sel && read_en)
      read_data <= regs[reg_idx];
  end

endmodule

`default_nettype wire

//--- io_devices/io_accumulator.sv
`default_nettype none

module io_accumulator
  import io_pkg::*;
(
  input wire clk,
  input wire reset,
  input wire sel,
  input wire write_en,
  input wire read_en,
  input wire [IO_ADDR_WIDTH-1:0] addr,
  input wire [IO_DATA_WIDTH-1:0] write_data,
  output logic [IO_DATA_WIDTH-1:0] read_data
);

  logic [IO_DATA_WIDTH-1:0] sum;

  // Load replaces the sum, add wraps at the data width
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      sum <= '0;
    else if (sel && write_en)
    begin
      if (addr == ACCUM_LOAD_ADDR)
        sum <= write_data;
      else if (addr == ACCUM_ADD_ADDR)
        sum <= sum + write_data;
    end
  end

  // Either address reads back the sum
  always_ff @(posedge clk)
  begin
    if (sel && read_en)
      read_data <= sum;
  end

endmodule

`default_nettype wire

//--- io_interconnect/io_interconnect.sv
`default_nettype none

module io_interconnect
  import io_pkg::*;
(
  input wire clk,
  input wire reset,

  // Core requests, one lane per core
  input wire [NUM_CORES-1:0] req_valid,
  input wire io_op_e [NUM_CORES-1:0] req_op,
  input wire [NUM_CORES-1:0][IO_ADDR_WIDTH-1:0] req_addr,
  input wire [NUM_CORES-1:0][IO_DATA_WIDTH-1:0] req_value,
  input wire [NUM_CORES-1:0][THREAD_IDX_WIDTH-1:0] req_thread,
  output logic [NUM_CORES-1:0] ready,

  // Responses back to the cores
  output logic rsp_valid,
  output logic [CORE_ID_WIDTH-1:0] rsp_core,
  output logic [THREAD_IDX_WIDTH-1:0] rsp_thread,
  output logic [IO_DATA_WIDTH-1:0] rsp_read_value,

  // IO bus
  output logic bus_write_en,
  output logic bus_read_en,
  output logic [IO_ADDR_WIDTH-1:0] bus_addr,
  output logic [IO_DATA_WIDTH-1:0] bus_write_data,
  input wire [IO_DATA_WIDTH-1:0] bus_read_data
);

  logic [NUM_CORES-1:0] grant_oh;
  logic [CORE_ID_WIDTH-1:0] grant_idx;
  logic granted;
  io_op_e grant_op;

  // Tags of the transaction now waiting for bus read data
  logic pending_valid;
  logic [CORE_ID_WIDTH-1:0] pending_core;
  logic [THREAD_IDX_WIDTH-1:0] pending_thread;

  rr_arbiter i_rr_arbiter (
    .clk(clk),
    .reset(reset),
    .request(req_valid),
    .update_pointer(1'b1),
    .grant_oh(grant_oh),
    .grant_idx(grant_idx)
  );

  // Ready doubles as the grant, so a core sees it in the granted cycle
  assign ready = grant_oh;
  assign granted = |grant_oh;
  assign grant_op = req_op[grant_idx];

  // Granted request goes straight onto the bus
  assign bus_write_en = granted && (grant_op == IO_WRITE);
  assign bus_read_en = granted && (grant_op == IO_READ);
  assign bus_addr = req_addr[grant_idx];
  assign bus_write_data = req_value[grant_idx];

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      pending_valid <= 1'b0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      pending_valid <= granted;
      rsp_valid <= pending_valid;
    end
  end

  // First stage holds the tags while the device returns data,
  // second stage lines them up with bus_read_data
  always_ff @(posedge clk)
  begin
    if (granted)
    begin
      pending_core <= grant_idx;
      pending_thread <= req_thread[grant_idx];
    end
    rsp_core <= pending_core;
    rsp_thread <= pending_thread;
    rsp_read_value <= bus_read_data;
  end

endmodule

`default_nettype wire

//--- io_subsystem.sv
`default_nettype none

module io_subsystem
  import io_pkg::*;
(
  input wire clk,
  input wire reset,
  input wire [NUM_CORES-1:0] req_valid,
  input wire io_op_e [NUM_CORES-1:0] req_op,
  input wire [NUM_CORES-1:0][IO_ADDR_WIDTH-1:0] req_addr,
  input wire [NUM_CORES-1:0][IO_DATA_WIDTH-1:0] req_value,
  input wire [NUM_CORES-1:0][THREAD_IDX_WIDTH-1:0] req_thread,
  output logic [NUM_CORES-1:0] ready,
  output logic rsp_valid,
  output logic [CORE_ID_WIDTH-1:0] rsp_core,
  output logic [THREAD_IDX_WIDTH-1:0] rsp_thread,
  output logic [IO_DATA_WIDTH-1:0] rsp_read_value
);

  // Shared IO bus
  logic bus_write_en;
  logic bus_read_en;
  logic [IO_ADDR_WIDTH-1:0] bus_addr;
  logic [IO_DATA_WIDTH-1:0] bus_write_data;
  logic [IO_DATA_WIDTH-1:0] bus_read_data;

  // Device selects and return data
  logic reg_sel;
  logic accum_sel;
  logic [IO_DATA_WIDTH-1:0] reg_read_data;
  logic [IO_DATA_WIDTH-1:0] accum_read_data;

  io_interconnect i_io_interconnect (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .req_op(req_op),
    .req_addr(req_addr),
    .req_value(req_value),
    .req_thread(req_thread),
    .ready(ready),
    .rsp_valid(rsp_valid),
    .rsp_core(rsp_core),
    .rsp_thread(rsp_thread),
    .rsp_read_value(rsp_read_value),
    .bus_write_en(bus_write_en),
    .bus_read_en(bus_read_en),
    .bus_addr(bus_addr),
    .bus_write_data(bus_write_data),
    .bus_read_data(bus_read_data)
  );

  io_bus_decoder i_io_bus_decoder (
    .clk(clk),
    .reset(reset),
    .bus_read_en(bus_read_en),
    .bus_write_en(bus_write_en),
    .bus_addr(bus_addr),
    .reg_sel(reg_sel),
    .accum_sel(accum_sel),
    .reg_read_data(reg_read_data),
    .accum_read_data(accum_read_data),
    .bus_read_data(bus_read_data)
  );

  io_register_bank i_io_register_bank (
    .clk(clk),
    .reset(reset),
    .sel(reg_sel),
    .write_en(bus_write_en),
    .read_en(bus_read_en),
    .addr(bus_addr),
    .write_data(bus_write_data),
    .read_data(reg_read_data)
  );

  io_accumulator i_io_accumulator (
    .clk(clk),
    .reset(reset),
    .sel(accum_sel),
    .write_en(bus_write_en),
    .read_en(bus_read_en),
    .addr(bus_addr),
    .write_data(bus_write_data),
    .read_data(accum_read_data)
  );

endmodule

`default_nettype wire

//--- dv/tb_io_subsystem.sv
`default_nettype none

module tb_io_subsystem
  import io_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CYCLES = 2000;
  localparam int ACCEPT_TIMEOUT = 16;
  localparam int DRAIN_TIMEOUT = 8;

  logic clk;
  logic reset;
  logic [NUM_CORES-1:0] req_valid;
  io_op_e [NUM_CORES-1:0] req_op;
  logic [NUM_CORES-1:0][IO_ADDR_WIDTH-1:0] req_addr;
  logic [NUM_CORES-1:0][IO_DATA_WIDTH-1:0] req_value;
  logic [NUM_CORES-1:0][THREAD_IDX_WIDTH-1:0] req_thread;
  logic [NUM_CORES-1:0] ready;
  logic rsp_valid;
  logic [CORE_ID_WIDTH-1:0] rsp_core;
  logic [THREAD_IDX_WIDTH-1:0] rsp_thread;
  logic [IO_DATA_WIDTH-1:0] rsp_read_value;

  integer seed;
  int error_count;
  int check_count;
  int wait_cycles [NUM_CORES];
  bit timed_out;

  // Reference model state
  logic [CORE_ID_WIDTH-1:0] model_pointer;
  logic [IO_DATA_WIDTH-1:0] model_regs [REG_BANK_WORDS];
  logic [IO_DATA_WIDTH-1:0] model_sum;

  // Expected responses, entry 2 is due in the current cycle
  logic exp_valid [3];
  logic [CORE_ID_WIDTH-1:0] exp_core [3];
  logic [THREAD_IDX_WIDTH-1:0] exp_thread [3];
  logic [IO_DATA_WIDTH-1:0] exp_value [3];

  initial clk = 1'b0;
  always #4 clk = ~clk;

  io_subsystem i_io_subsystem (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .req_op(req_op),
    .req_addr(req_addr),
    .req_value(req_value),
    .req_thread(req_thread),
    .ready(ready),
    .rsp_valid(rsp_valid),
    .rsp_core(rsp_core),
    .rsp_thread(rsp_thread),
    .rsp_read_value(rsp_read_value)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // First requesting core at or after the pointer
  function automatic logic [NUM_CORES-1:0] predict_grant(input logic [NUM_CORES-1:0] request,
                                                        input logic [CORE_ID_WIDTH-1:0] pointer);
    logic [NUM_CORES-1:0] grant;
    int core;
    grant = '0;
    for (int i = 0; i < NUM_CORES; i++)
    begin
      core = (int'(pointer) + i) % NUM_CORES;
      if (grant == '0 && request[core])
        grant[core] = 1'b1;
    end
    return grant;
  endfunction

  // Mostly register bank words, some accumulator accesses, a few holes in the map
  function automatic logic [IO_ADDR_WIDTH-1:0] pick_address();
    int kind;
    logic [IO_ADDR_WIDTH-1:0] addr;
    kind = int'($unsigned($random(seed)) % 16);
    if (kind < 10)
      addr = REG_BANK_BASE + (IO_ADDR_WIDTH'(4'($random(seed))) << 2);
    else if (kind < 13)
      addr = ACCUM_ADD_ADDR;
    else if (kind < 14)
      addr = ACCUM_LOAD_ADDR;
    else
    begin
      case (2'($random(seed)))
        2'd0: addr = 16'h0048;
        2'd1: addr = 16'h0080;
        2'd2: addr = 16'h1000;
        default: addr = 16'hfffc;
      endcase
    end
    return addr;
  endfunction

  // Core agents, a request is held until it was accepted
  task automatic drive_cores(input logic [NUM_CORES-1:0] accepted, input bit issue_all);
    for (int c = 0; c < NUM_CORES; c++)
    begin
      if (accepted[c] || !req_valid[c])
      begin
        wait_cycles[c] = 0;
        if (issue_all || ($unsigned($random(seed)) % 4) != 0)
        begin
          req_valid[c] = 1'b1;
          req_op[c] = ($random(seed) & 1) ? IO_WRITE : IO_READ;
          req_addr[c] = pick_address();
          req_value[c] = $random(seed);
          req_thread[c] = THREAD_IDX_WIDTH'($random(seed));
        end
        else
          req_valid[c] = 1'b0;
      end
      else
      begin
        wait_cycles[c]++;
        if (wait_cycles[c] > ACCEPT_TIMEOUT)
        begin
          $display("timeout: core %0d request not accepted within %0d cycles", c,
                   ACCEPT_TIMEOUT);
          error_count++;
          timed_out = 1'b1;
        end
      end
    end
  endtask

  // Device effect of one grant and the response it should produce
  task automatic apply_grant(input int core);
    logic [IO_ADDR_WIDTH-1:0] offset;
    logic [IO_DATA_WIDTH-1:0] value;
    offset = req_addr[core] - REG_BANK_BASE;
    value = '0;
    if (req_op[core] == IO_WRITE)
    begin
      if (offset < REG_BANK_BYTES)
        model_regs[offset[5:2]] = req_value[core];
      else if (req_addr[core] == ACCUM_ADD_ADDR)
        model_sum = model_sum + req_value[core];
      else if (req_addr[core] == ACCUM_LOAD_ADDR)
        model_sum = req_value[core];
    end
    else if (offset < REG_BANK_BYTES)
      value = model_regs[offset[5:2]];
    else if (req_addr[core] == ACCUM_ADD_ADDR || req_addr[core] == ACCUM_LOAD_ADDR)
      value = model_sum;
    exp_valid[0] = 1'b1;
    exp_core[0] = CORE_ID_WIDTH'(core);
    exp_thread[0] = req_thread[core];
    exp_value[0] = value;
    model_pointer = CORE_ID_WIDTH'((core + 1) % NUM_CORES);
  endtask

  // Runs mid-cycle, when inputs and outputs are settled
  task automatic check_cycle();
    logic [NUM_CORES-1:0] expected_grant;
    expected_grant = predict_grant(req_valid, model_pointer);
    check_value("ready", 32'(ready), 32'(expected_grant));
    check_value("ready one-hot", 32'($countones(ready) <= 1), 32'd1);
    check_value("ready without request", 32'(ready & ~req_valid), 32'd0);
    for (int i = 2; i > 0; i--)
    begin
      exp_valid[i] = exp_valid[i-1];
      exp_core[i] = exp_core[i-1];
      exp_thread[i] = exp_thread[i-1];
      exp_value[i] = exp_value[i-1];
    end
    exp_valid[0] = 1'b0;
    for (int c = 0; c < NUM_CORES; c++)
    begin
      if (expected_grant[c])
        apply_grant(c);
    end
    check_value("rsp_valid", 32'(rsp_valid), 32'(exp_valid[2]));
    if (exp_valid[2])
    begin
      check_value("rsp_core", 32'(rsp_core), 32'(exp_core[2]));
      check_value("rsp_thread", 32'(rsp_thread), 32'(exp_thread[2]));
      check_value("rsp_read_value", rsp_read_value, exp_value[2]);
    end
  endtask

  initial
  begin
    logic [NUM_CORES-1:0] accepted;
    int cycle;
    int drain;
    seed = 32'h1216_8ea8;
    error_count = 0;
    check_count = 0;
    timed_out = 1'b0;
    reset = 1'b1;
    req_valid = '0;
    req_op = {NUM_CORES{IO_READ}};
    req_addr = '0;
    req_value = '0;
    req_thread = '0;
    model_pointer = '0;
    model_sum = '0;
    for (int i = 0; i < REG_BANK_WORDS; i++)
      model_regs[i] = '0;
    for (int i = 0; i < 3; i++)
    begin
      exp_valid[i] = 1'b0;
      exp_core[i] = '0;
      exp_thread[i] = '0;
      exp_value[i] = '0;
    end
    for (int c = 0; c < NUM_CORES; c++)
      wait_cycles[c] = 0;

    // Outputs stay quiet in reset and while no core requests
    repeat (2)
    begin
      @(negedge clk);
      check_value("ready in reset", 32'(ready), 32'd0);
      check_value("rsp_valid in reset", 32'(rsp_valid), 32'd0);
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      check_cycle();
    end

    // All cores request in the first cycle, so core 0 must win
    accepted = '0;
    cycle = 0;
    while (cycle < NUM_CYCLES && !timed_out)
    begin
      @(posedge clk);
      #1;
      drive_cores(accepted, cycle == 0);
      @(negedge clk);
      if (cycle == 0)
        check_value("first contested grant", 32'(ready), 32'd1);
      check_cycle();
      accepted = ready;
      cycle++;
    end

    // Let the last grants come back
    @(posedge clk);
    #1;
    req_valid = '0;
    drain = 0;
    while ((exp_valid[0] || exp_valid[1]) && !timed_out)
    begin
      @(negedge clk);
      check_cycle();
      drain++;
      if (drain > DRAIN_TIMEOUT)
      begin
        $display("timeout: responses still pending after %0d idle cycles", DRAIN_TIMEOUT);
        error_count++;
        timed_out = 1'b1;
      end
    end
    repeat (2)
    begin
      @(negedge clk);
      check_cycle();
    end

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- io_subsystem.f
common/io_pkg.sv
logic/rr_arbiter.sv
logic/io_bus_decoder.sv
io_devices/io_register_bank.sv
io_devices/io_accumulator.sv
io_interconnect/io_interconnect.sv
io_subsystem.sv
dv/tb_io_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the IO subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_io_subsystem \
  -f io_subsystem.f -o sim_io_subsystem

./obj_dir/sim_io_subsystem > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
